/* source/neo_loader_pkg.sv */
`default_nettype none

package neo_loader_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [26:0] dl_addr_t;
	typedef logic [31:0] size_t;
	typedef logic [22:0] port1_addr_t; // Bank 3 word address
	typedef logic [24:0] port2_addr_t; // Banks 0-2 word address

	// Same order as the size fields of the .NEO header
	typedef enum logic [2:0] {REG_P, REG_S, REG_M, REG_V1, REG_V2, REG_C, REG_DONE} region_e;

	typedef struct packed {
		logic     downl;
		logic     wr;
		dl_addr_t addr;
		byte_t    dout;
	} ioctl_s;

	// P ends up in the low bits, matching the little-endian shift-in
	typedef struct packed {
		size_t c;
		size_t v2;
		size_t v1;
		size_t m;
		size_t s;
		size_t p;
	} rom_sizes_s;

	typedef struct packed {
		size_t c;
		size_t v1;
		size_t v2;
		size_t p2;
	} rom_masks_s;

	typedef struct packed {
		logic        req; // Toggles once per write
		port2_addr_t addr;
		word_t       d;
	} port_req_s;

	localparam size_t HEADER_BYTES = 32'd4096;
	localparam size_t P1_BYTES     = 32'h0010_0000;
	localparam size_t FIX_BASE     = 32'h00E0_0000;
	localparam size_t MROM_BASE    = 32'h00F0_0000;

	// Address bits needed to cover value bytes
	function automatic logic [5:0] ceil_bit(input size_t value);
		logic [5:0]  msb;
		int unsigned ones;
		msb = '0;
		ones = 0;
		for (int i = 0; i < 32; i++) begin
			if (value[i]) begin
				msb = 6'(i);
				ones++;
			end
		end
		return (ones > 1) ? msb + 6'd1 : msb;
	endfunction

endpackage

`default_nettype wire

/* source/neo_header_parser.sv */
`default_nettype none

module neo_header_parser #(
	parameter int PAGE_BYTES = 128
) (
	input  wire logic                        CLK_48M,
	input  wire logic                        pll_locked,
	input  wire neo_loader_pkg::ioctl_s      ioctl_i,
	output neo_loader_pkg::rom_sizes_s       sizes_o,
	output neo_loader_pkg::rom_masks_s       masks_o,
	output neo_loader_pkg::region_e          region_o,
	output logic                             page_done_o,
	output neo_loader_pkg::region_e          page_region_o
);

	import neo_loader_pkg::*;

	localparam int PAGE_W = $clog2(PAGE_BYTES);

	dl_addr_t offset; // Byte count within the current region
	dl_addr_t cur_size;
	logic     dl_wr;
	logic     in_header;
	logic     size_field;
	logic     last_header;
	logic     page_end;

	function automatic size_t region_size(input region_e r, input rom_sizes_s sz);
		case (r)
			REG_P:   return sz.p;
			REG_S:   return sz.s;
			REG_M:   return sz.m;
			REG_V1:  return sz.v1;
			REG_V2:  return sz.v2;
			REG_C:   return sz.c;
			default: return '0;
		endcase
	endfunction

	// First region at or after from that holds any data
	function automatic region_e first_region(input int unsigned from, input rom_sizes_s sz);
		region_e r;
		r = REG_DONE;
		for (int i = 5; i >= 0; i--) begin
			if (i >= from && region_size(region_e'(i), sz) != '0)
				r = region_e'(i);
		end
		return r;
	endfunction

	function automatic size_t mask_of(input size_t size);
		return (size_t'(1) << ceil_bit(size)) - size_t'(1);
	endfunction

	assign dl_wr       = ioctl_i.downl && ioctl_i.wr;
	assign in_header   = ioctl_i.addr < dl_addr_t'(HEADER_BYTES);
	assign size_field  = ioctl_i.addr >= dl_addr_t'(4) && ioctl_i.addr < dl_addr_t'(28);
	assign last_header = ioctl_i.addr == dl_addr_t'(HEADER_BYTES - 1);
	assign page_end    = &ioctl_i.addr[PAGE_W-1:0];
	assign cur_size    = dl_addr_t'(region_size(region_o, sizes_o));

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			sizes_o       <= '0;
			masks_o       <= '0;
			region_o      <= REG_DONE;
			offset        <= '0;
			page_done_o   <= 1'b0;
			page_region_o <= REG_DONE;
		end else begin
			page_done_o <= 1'b0;

			if (ioctl_i.downl) begin
				masks_o.c  <= mask_of(sizes_o.c);
				masks_o.v1 <= mask_of(sizes_o.v1);
				masks_o.v2 <= mask_of(sizes_o.v2);
				masks_o.p2 <= (sizes_o.p > P1_BYTES) ? mask_of(sizes_o.p - P1_BYTES) : '0;
			end

			if (dl_wr && in_header) begin
				region_o <= REG_DONE;
				offset   <= '0;
				if (size_field)
					sizes_o <= rom_sizes_s'({ioctl_i.dout, sizes_o[$bits(rom_sizes_s)-1:8]});
				if (last_header)
					region_o <= first_region(0, sizes_o);
			end else if (dl_wr && region_o != REG_DONE) begin
				if (page_end) begin
					page_done_o   <= 1'b1;
					page_region_o <= region_o;
				end
				if (offset + dl_addr_t'(1) == cur_size) begin
					offset   <= '0;
					region_o <= first_region(int'(region_o) + 1, sizes_o); // Skips empty regions
				end else begin
					offset <= offset + dl_addr_t'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/neo_dl_fifo.sv */
`default_nettype none

module neo_dl_fifo #(
	parameter int PAGE_BYTES = 128
) (
	input  wire logic                          CLK_48M,
	input  wire logic                          pll_locked,
	input  wire neo_loader_pkg::ioctl_s        ioctl_i,
	input  wire neo_loader_pkg::region_e       region_i,
	input  wire logic                          page_done_i,
	input  wire logic [$clog2(PAGE_BYTES)-2:0] rd_index_i,
	output neo_loader_pkg::word_t              rd_data_o
);

	import neo_loader_pkg::*;

	localparam int PAGE_W = $clog2(PAGE_BYTES);
	localparam int WORDS  = PAGE_BYTES / 2;

	// Two pages, byte lanes written separately
	byte_t [1:0] mem [2*WORDS];

	logic              page; // Page being filled
	logic [PAGE_W-1:0] wr_pos;
	logic              wr_en;

	assign wr_en = ioctl_i.downl && ioctl_i.wr && region_i != REG_DONE;

	// Tile byte order for FIX and sprite data
	always_comb begin
		wr_pos = ioctl_i.addr[PAGE_W-1:0];
		case (region_i)
			REG_S: begin
				wr_pos[6:0] = {ioctl_i.addr[6:5], ioctl_i.addr[2:0], ~ioctl_i.addr[4],
					ioctl_i.addr[3]};
			end
			REG_C: begin
				wr_pos[6:0] = {ioctl_i.addr[5:2], ~ioctl_i.addr[6], ioctl_i.addr[0],
					ioctl_i.addr[1]};
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (wr_en)
			mem[{page, wr_pos[PAGE_W-1:1]}][wr_pos[0]] <= ioctl_i.dout; // Lane 0 is low byte
		rd_data_o <= mem[{~page, rd_index_i}];
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked)
			page <= 1'b0;
		else if (page_done_i)
			page <= ~page;
	end

endmodule

`default_nettype wire

/* source/neo_sdram_writer.sv */
`default_nettype none

module neo_sdram_writer #(
	parameter int PAGE_BYTES = 128
) (
	input  wire logic                          CLK_48M,
	input  wire logic                          pll_locked,
	input  wire logic                          page_done_i,
	input  wire neo_loader_pkg::region_e       page_region_i,
	input  wire neo_loader_pkg::rom_sizes_s    sizes_i,
	output logic [$clog2(PAGE_BYTES)-2:0]      rd_index_o,
	input  wire neo_loader_pkg::word_t         rd_data_i,
	output neo_loader_pkg::port_req_s          port1_o,
	input  wire logic                          port1_ack_i,
	output neo_loader_pkg::port_req_s          port2_o,
	input  wire logic                          port2_ack_i,
	output logic                               busy_o
);

	import neo_loader_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_e;

	state_e      state;
	region_e     cur_region; // Region of the page being sent
	size_t       word_off;
	logic        req1;
	logic        req2;
	size_t       base;
	size_t       byte_addr;
	port1_addr_t p1_addr;
	port2_addr_t p2_addr;
	logic        on_port1;
	logic        ack_ok;

	// Bank 3 holds P, S, M; banks 0-2 hold C then V1 then V2
	always_comb begin
		case (cur_region)
			REG_S:   base = FIX_BASE;
			REG_M:   base = MROM_BASE;
			REG_V1:  base = sizes_i.c;
			REG_V2:  base = sizes_i.c + sizes_i.v1;
			default: base = '0;
		endcase
		byte_addr = base + {word_off[30:0], 1'b0};
	end

	assign p1_addr  = byte_addr[23:1];
	assign p2_addr  = byte_addr[25:1];
	assign on_port1 = cur_region inside {REG_P, REG_S, REG_M};
	assign ack_ok   = on_port1 ? (req1 == port1_ack_i) : (req2 == port2_ack_i);
	assign busy_o   = state != ST_IDLE;

	// Data comes straight from the FIFO read register, index held until ack
	assign port1_o = '{req: req1, addr: {2'b00, p1_addr}, d: rd_data_i};
	assign port2_o = '{req: req2, addr: p2_addr, d: rd_data_i};

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			state      <= ST_IDLE;
			cur_region <= REG_DONE;
			word_off   <= '0;
			rd_index_o <= '0;
			req1       <= 1'b0;
			req2       <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (page_done_i) begin
						if (page_region_i != cur_region)
							word_off <= '0; // New region starts at its base
						cur_region <= page_region_i;
						rd_index_o <= '0;
						state      <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (on_port1)
						req1 <= ~req1;
					else
						req2 <= ~req2;
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (ack_ok) begin
						word_off   <= word_off + size_t'(1);
						rd_index_o <= rd_index_o + 1'b1;
						state      <= (&rd_index_o) ? ST_IDLE : ST_REQ; // Last word of page
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/neo_cart_loader.sv */
`default_nettype none

module neo_cart_loader #(
	parameter int PAGE_BYTES = 128
) (
	input  wire logic                     CLK_48M,
	input  wire logic                     pll_locked,
	input  wire neo_loader_pkg::ioctl_s   ioctl_i,
	output neo_loader_pkg::port_req_s     port1_o,
	input  wire logic                     port1_ack_i,
	output neo_loader_pkg::port_req_s     port2_o,
	input  wire logic                     port2_ack_i,
	output neo_loader_pkg::rom_masks_s    masks_o,
	output logic                          busy_o
);

	import neo_loader_pkg::*;

	localparam int IDX_W = $clog2(PAGE_BYTES) - 1;

	rom_sizes_s       sizes;
	region_e          region;
	region_e          page_region;
	logic             page_done;
	logic [IDX_W-1:0] rd_index;
	word_t            rd_data;

	neo_header_parser #(.PAGE_BYTES(PAGE_BYTES)) u_parser (
		.CLK_48M       (CLK_48M),
		.pll_locked    (pll_locked),
		.ioctl_i       (ioctl_i),
		.sizes_o       (sizes),
		.masks_o       (masks_o),
		.region_o      (region),
		.page_done_o   (page_done),
		.page_region_o (page_region)
	);

	neo_dl_fifo #(.PAGE_BYTES(PAGE_BYTES)) u_fifo (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl_i     (ioctl_i),
		.region_i    (region),
		.page_done_i (page_done),
		.rd_index_i  (rd_index),
		.rd_data_o   (rd_data)
	);

	neo_sdram_writer #(.PAGE_BYTES(PAGE_BYTES)) u_writer (
		.CLK_48M       (CLK_48M),
		.pll_locked    (pll_locked),
		.page_done_i   (page_done),
		.page_region_i (page_region),
		.sizes_i       (sizes),
		.rd_index_o    (rd_index),
		.rd_data_i     (rd_data),
		.port1_o       (port1_o),
		.port1_ack_i   (port1_ack_i),
		.port2_o       (port2_o),
		.port2_ack_i   (port2_ack_i),
		.busy_o        (busy_o)
	);

endmodule

`default_nettype wire

/* testbench/neo_loader_chk.sv */
`default_nettype none

module neo_loader_chk (
	input wire logic                      CLK_48M,
	input wire logic                      pll_locked,
	input wire logic                      page_done,
	input wire logic                      busy_o,
	input wire neo_loader_pkg::port_req_s port1_o,
	input wire logic                      port1_ack_i,
	input wire neo_loader_pkg::port_req_s port2_o,
	input wire logic                      port2_ack_i
);

	timeunit 1ns;
	timeprecision 1ps;

	int fails = 0;

	a_p1_stable: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		(port1_o.req != port1_ack_i) |=> (port1_o.req == port1_ack_i) ||
		($stable(port1_o.addr) && $stable(port1_o.d)))
		else begin fails++; $error("port1 addr or d moved while a request was outstanding"); end

	a_p2_stable: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		(port2_o.req != port2_ack_i) |=> (port2_o.req == port2_ack_i) ||
		($stable(port2_o.addr) && $stable(port2_o.d)))
		else begin fails++; $error("port2 addr or d moved while a request was outstanding"); end

	// Next page filled before the previous upload finished
	a_no_overrun: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		page_done |-> !busy_o)
		else begin fails++; $error("page done arrived while the writer was busy"); end

	a_req_reset: assert property (@(posedge CLK_48M)
		(!pll_locked && $past(!pll_locked)) |-> (!port1_o.req && !port2_o.req))
		else begin fails++; $error("request bit high during reset"); end

endmodule

bind neo_cart_loader neo_loader_chk u_chk (
	.CLK_48M     (CLK_48M),
	.pll_locked  (pll_locked),
	.page_done   (page_done),
	.busy_o      (busy_o),
	.port1_o     (port1_o),
	.port1_ack_i (port1_ack_i),
	.port2_o     (port2_o),
	.port2_ack_i (port2_ack_i)
);

`default_nettype wire

/* testbench/neo_loader_monitor.sv */
`default_nettype none

module neo_loader_monitor #(
	parameter int PAGE_BYTES = 128
) (
	input  wire logic                      CLK_48M,
	input  wire logic                      pll_locked,
	input  wire neo_loader_pkg::ioctl_s    ioctl_i,
	input  wire neo_loader_pkg::port_req_s port1_i,
	input  wire neo_loader_pkg::port_req_s port2_i,
	input  wire logic                      busy_i,
	input  wire neo_loader_pkg::rom_masks_s masks_i,
	input  wire logic                      done1_i,
	input  wire neo_loader_pkg::port_req_s wr1_i,
	input  wire logic                      done2_i,
	input  wire neo_loader_pkg::port_req_s wr2_i,
	output int                             err_cnt_o,
	output int                             pending_o
);

	timeunit 1ns;
	timeprecision 1ps;

	import neo_loader_pkg::*;

	int unsigned sizes [6]; // P S M V1 V2 C
	int          region = 6;
	int unsigned off = 0;
	logic        in_hdr = 1'b0;
	logic        downl_d = 1'b0;
	logic        was_locked = 1'b0;
	logic [15:0] exp1 [int unsigned];
	logic [15:0] exp2 [int unsigned];
	int unsigned q1 [$];
	int unsigned q2 [$];

	initial begin
		err_cnt_o = 0;
		pending_o = 0;
	end

	function automatic int next_region(input int from);
		for (int i = from; i < 6; i++)
			if (sizes[i] != 0)
				return i;
		return 6;
	endfunction

	function automatic int unsigned base_byte(input int r);
		case (r)
			1:       return 32'h00E0_0000;
			2:       return 32'h00F0_0000;
			3:       return sizes[5];
			4:       return sizes[5] + sizes[3];
			default: return 0;
		endcase
	endfunction

	function automatic longint unsigned mask_for(input longint unsigned s);
		int n;
		n = 0;
		while ((64'd1 << n) < s)
			n++;
		return (64'd1 << n) - 1;
	endfunction

	// Port, word address and byte lane of one image byte
	function automatic void byte_target(input int r, input int unsigned o, output bit on_port2,
		output int unsigned waddr, output bit lane);
		logic [6:0] a;
		logic [6:0] pos;
		a = o[6:0];
		case (r)
			1:       pos = {a[6], a[5], a[2], a[1], a[0], ~a[4], a[3]}; // FIX tiles
			5:       pos = {a[5], a[4], a[3], a[2], ~a[6], a[0], a[1]}; // Sprite tiles
			default: pos = a;
		endcase
		on_port2 = r >= 3;
		waddr    = (base_byte(r) + (o & ~(PAGE_BYTES - 1)) + {pos[6:1], 1'b0}) >> 1;
		lane     = pos[0];
	endfunction

	task automatic compare_val(input string name, input longint unsigned got,
		input longint unsigned want);
		if (got != want) begin
			$display("ERR %s got %h expected %h", name, got, want);
			err_cnt_o++;
		end
	endtask

	task automatic observe(input int unsigned addr, input byte_t d);
		bit          p2;
		bit          lane;
		int unsigned wa;
		int unsigned first;
		if (addr < 4096) begin
			in_hdr = 1'b1;
			region = 6;
			if (addr >= 4 && addr < 28)
				sizes[(addr - 4) / 4][8 * ((addr - 4) % 4) +: 8] = d;
			if (addr == 4095) begin
				region = next_region(0);
				off    = 0;
				in_hdr = 1'b0;
			end
		end else if (region < 6) begin
			byte_target(region, off, p2, wa, lane);
			if (p2) begin
				if (!exp2.exists(wa))
					exp2[wa] = 16'h0000;
				exp2[wa][8 * lane +: 8] = d;
			end else begin
				if (!exp1.exists(wa))
					exp1[wa] = 16'h0000;
				exp1[wa][8 * lane +: 8] = d;
			end
			if (off % PAGE_BYTES == PAGE_BYTES - 1) begin // Page complete
				first = base_byte(region) / 2 + (off / PAGE_BYTES) * (PAGE_BYTES / 2);
				for (int k = 0; k < PAGE_BYTES / 2; k++)
					if (p2)
						q2.push_back(first + k);
					else
						q1.push_back(first + k);
			end
			off++;
			if (off == sizes[region]) begin
				region = next_region(region + 1);
				off    = 0;
			end
		end
	endtask

	task automatic check_write(input bit p2, input port_req_s w);
		int unsigned want;
		if (in_hdr) begin
			$display("A write on port %0d appeared while the header was streaming", p2 + 1);
			err_cnt_o++;
		end else if ((p2 && q2.size() == 0) || (!p2 && q1.size() == 0)) begin
			$display("Port %0d accepted a write at %h that no image byte calls for",
				p2 + 1, w.addr);
			err_cnt_o++;
		end else begin
			want = p2 ? q2.pop_front() : q1.pop_front();
			compare_val(p2 ? "port2_o.addr" : "port1_o.addr", w.addr, want);
			compare_val(p2 ? "port2_o.d" : "port1_o.d", w.d, p2 ? exp2[want] : exp1[want]);
		end
	endtask

	always @(posedge CLK_48M) begin
		if (pll_locked) begin
			if (!was_locked) begin
				compare_val("busy_o", busy_i, 0);
				compare_val("port1_o.req", port1_i.req, 0);
				compare_val("port2_o.req", port2_i.req, 0);
				compare_val("masks_o.c", masks_i.c, 0);
				compare_val("masks_o.v1", masks_i.v1, 0);
				compare_val("masks_o.v2", masks_i.v2, 0);
				compare_val("masks_o.p2", masks_i.p2, 0);
			end
			if (in_hdr)
				compare_val("busy_o", busy_i, 0);
			if (ioctl_i.downl && ioctl_i.wr)
				observe(ioctl_i.addr, ioctl_i.dout);
			if (done1_i)
				check_write(1'b0, wr1_i);
			if (done2_i)
				check_write(1'b1, wr2_i);
			if (downl_d && !ioctl_i.downl) begin // End of an image
				compare_val("masks_o.c", masks_i.c, mask_for(sizes[5]));
				compare_val("masks_o.v1", masks_i.v1, mask_for(sizes[3]));
				compare_val("masks_o.v2", masks_i.v2, mask_for(sizes[4]));
				compare_val("masks_o.p2", masks_i.p2,
					(sizes[0] > 32'h0010_0000) ? mask_for(sizes[0] - 32'h0010_0000) : 0);
			end
			downl_d = ioctl_i.downl;
		end
		was_locked = pll_locked;
		pending_o  = q1.size() + q2.size();
	end

endmodule

`default_nettype wire

/* testbench/tb_neo_cart_loader.sv */
`default_nettype none

module tb_neo_cart_loader;

	timeunit 1ns;
	timeprecision 1ps;

	import neo_loader_pkg::*;

	localparam int PAGE_BYTES     = 128;
	localparam int IMG1_DATA      = 256 + 128 + 128 + 256 + 128 + 256;
	localparam int IMG2_DATA      = 128 + 256 + 128 + 128 + 0 + 384;
	localparam int TOTAL_BYTES    = 3 * 4096 + IMG1_DATA + IMG2_DATA;
	localparam int TIMEOUT_CYCLES = 6 * TOTAL_BYTES + 2000;

	logic       CLK_48M;
	logic       pll_locked;
	ioctl_s     ioctl;
	port_req_s  port1;
	port_req_s  port2;
	logic       ack1;
	logic       ack2;
	rom_masks_s masks;
	logic       busy;
	integer     data_seed = 32'h255;
	integer     delay_seed = 32'h255;
	int         cnt1;
	int         cnt2;
	logic       rec1_v;
	logic       rec2_v;
	port_req_s  rec1;
	port_req_s  rec2;
	int         err_cnt;
	int         pending;
	int         cycles = 0;

	neo_cart_loader #(.PAGE_BYTES(PAGE_BYTES)) u_neo_cart_loader (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl_i     (ioctl),
		.port1_o     (port1),
		.port1_ack_i (ack1),
		.port2_o     (port2),
		.port2_ack_i (ack2),
		.masks_o     (masks),
		.busy_o      (busy)
	);

	neo_loader_monitor #(.PAGE_BYTES(PAGE_BYTES)) u_monitor (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ioctl_i    (ioctl),
		.port1_i    (port1),
		.port2_i    (port2),
		.busy_i     (busy),
		.masks_i    (masks),
		.done1_i    (rec1_v),
		.wr1_i      (rec1),
		.done2_i    (rec2_v),
		.wr2_i      (rec2),
		.err_cnt_o  (err_cnt),
		.pending_o  (pending)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #50 CLK_48M = ~CLK_48M;
	end

	// SDRAM port models, ack after 0 to 4 cycles
	always @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			ack1   <= 1'b0;
			ack2   <= 1'b0;
			cnt1   <= 0;
			cnt2   <= 0;
			rec1_v <= 1'b0;
			rec2_v <= 1'b0;
		end else begin
			rec1_v <= 1'b0;
			rec2_v <= 1'b0;
			if (port1.req != ack1) begin
				if (cnt1 == 0) begin
					ack1   <= port1.req;
					rec1   <= port1;
					rec1_v <= 1'b1;
					cnt1   <= int'($unsigned($random(delay_seed)) % 5);
				end else begin
					cnt1 <= cnt1 - 1;
				end
			end
			if (port2.req != ack2) begin
				if (cnt2 == 0) begin
					ack2   <= port2.req;
					rec2   <= port2;
					rec2_v <= 1'b1;
					cnt2   <= int'($unsigned($random(delay_seed)) % 5);
				end else begin
					cnt2 <= cnt2 - 1;
				end
			end
		end
	end

	task automatic send_byte(input int unsigned addr, input byte_t d);
		@(posedge CLK_48M);
		ioctl <= '{downl: 1'b1, wr: 1'b1, addr: dl_addr_t'(addr), dout: d};
		@(posedge CLK_48M);
		ioctl.wr <= 1'b0;
		repeat (2) @(posedge CLK_48M);
	endtask

	task automatic send_image(input int unsigned p, input int unsigned s, input int unsigned m,
		input int unsigned v1, input int unsigned v2, input int unsigned c,
		input int unsigned data_bytes);
		int unsigned sz [6];
		byte_t       d;
		sz = '{p, s, m, v1, v2, c};
		for (int unsigned a = 0; a < 4096; a++) begin
			d = 8'h00;
			if (a >= 4 && a < 28)
				d = sz[(a - 4) / 4][8 * ((a - 4) % 4) +: 8]; // Little-endian sizes
			send_byte(a, d);
		end
		for (int unsigned a = 0; a < data_bytes; a++)
			send_byte(4096 + a, byte_t'($random(data_seed)));
		@(posedge CLK_48M);
		ioctl.downl <= 1'b0;
		repeat (4) @(posedge CLK_48M);
		while (busy)
			@(posedge CLK_48M);
	endtask

	initial begin
		ioctl      = '0;
		pll_locked = 1'b0;
		repeat (2) @(posedge CLK_48M);
		pll_locked <= 1'b1;
		send_image(256, 128, 128, 256, 128, 256, IMG1_DATA);
		send_image(128, 256, 128, 128, 0, 384, IMG2_DATA);
		send_image(32'h0018_0000, 128, 128, 128, 128, 128, 0); // Header only, banked P
		repeat (4) @(posedge CLK_48M);
		$display("Errors: %0d mismatches, %0d writes missing, %0d assertion failures",
			err_cnt, pending, u_neo_cart_loader.u_chk.fails);
		if (err_cnt == 0 && pending == 0 && u_neo_cart_loader.u_chk.fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	always @(posedge CLK_48M) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the loader did not finish", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* compile.f */
source/neo_loader_pkg.sv
source/neo_header_parser.sv
source/neo_dl_fifo.sv
source/neo_sdram_writer.sv
source/neo_cart_loader.sv
testbench/neo_loader_chk.sv
testbench/neo_loader_monitor.sv
testbench/tb_neo_cart_loader.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_neo_cart_loader -f compile.f -o sim_neo_cart_loader

# The run may stop early on an assertion, the log decides
./obj_dir/sim_neo_cart_loader +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
	exit 1
fi
exit 0
